// File: design/bev_pkg.sv
package bev_pkg;

    typedef logic [11:0] ing_amt_t;
    // Signed so a make result below zero shows up as run-out
    typedef logic signed [12:0] ing_sum_t;
    typedef logic [7:0] box_no_t;
    typedef logic [7:0] month_t;
    typedef logic [7:0] day_t;
    typedef logic [63:0] record_t;

    typedef enum logic [1:0]
    {
        make_drink = 2'd0,
        supply     = 2'd1,
        check_date = 2'd2
    } action_t;

    typedef enum logic [2:0]
    {
        black_tea                = 3'd0,
        milk_tea                 = 3'd1,
        extra_milk_tea           = 3'd2,
        green_tea                = 3'd3,
        green_milk_tea           = 3'd4,
        pineapple_juice          = 3'd5,
        super_pineapple_tea      = 3'd6,
        super_pineapple_milk_tea = 3'd7
    } bev_type_t;

    typedef enum logic [1:0]
    {
        size_s = 2'd0,
        size_m = 2'd1,
        size_l = 2'd2
    } bev_size_t;

    typedef enum logic [1:0]
    {
        no_err = 2'd0,
        no_exp = 2'd1,
        no_ing = 2'd2,
        ing_of = 2'd3
    } err_msg_t;

    localparam int ing_max = 4095;
    localparam int vol_s = 480;
    localparam int vol_m = 720;
    localparam int vol_l = 960;

    // Lane order is black tea, green tea, milk, pineapple juice
    localparam int num_ing = 4;

    // Stock record fields from the top bit down
    localparam int rec_black_tea_lsb = 52;
    localparam int rec_green_tea_lsb = 40;
    localparam int rec_month_lsb     = 32;
    localparam int rec_milk_lsb      = 20;
    localparam int rec_pineapple_lsb = 8;
    localparam int rec_day_lsb       = 0;

    // Field position of each lane in lane order
    localparam int ing_lsb [num_ing] = '{
        rec_black_tea_lsb,
        rec_green_tea_lsb,
        rec_milk_lsb,
        rec_pineapple_lsb
    };

endpackage

// File: design/ingredient_lane.sv
`timescale 1ns/1ps

module ingredient_lane import bev_pkg::*;
#(
    parameter int lane_idx = 0
)
(
    input  logic       clk,
    input  logic       sup_capture,
    input  logic [1:0] sup_cnt,
    input  ing_amt_t   sup_amt,
    input  ing_amt_t   stock,
    input  ing_amt_t   demand,
    output ing_amt_t   made,
    output logic       run_out,
    output ing_amt_t   supplied,
    output logic       overflow
);

    ing_amt_t sup_q;
    ing_sum_t diff;
    // Unsigned sum reaching twice the ingredient maximum
    logic [$bits(ing_sum_t)-1:0] sum;

    // Supply pulses arrive in lane order
    always_ff @(posedge clk)
    begin
        if (sup_capture && sup_cnt == 2'(lane_idx))
            sup_q <= sup_amt;
    end

    assign diff = ing_sum_t'({1'b0, stock}) - ing_sum_t'({1'b0, demand});
    assign run_out = (diff < 0);
    assign made = diff[$bits(ing_amt_t)-1:0];

    assign sum = {1'b0, stock} + {1'b0, sup_q};
    assign overflow = (sum > $bits(sum)'(ing_max));
    assign supplied = overflow ? ing_amt_t'(ing_max) : sum[$bits(ing_amt_t)-1:0];

endmodule

// File: design/recipe_decode.sv
`timescale 1ns/1ps

module recipe_decode import bev_pkg::*;
(
    input  bev_type_t cur_type,
    input  bev_size_t cur_size,
    output ing_amt_t  demand [num_ing]
);

    ing_amt_t base;
    ing_amt_t half;
    ing_amt_t quarter;
    ing_amt_t three_q;

    always_comb
    begin
        case (cur_size)
            size_s:
                base = ing_amt_t'(vol_s);
            size_m:
                base = ing_amt_t'(vol_m);
            size_l:
                base = ing_amt_t'(vol_l);
            default:
                base = ing_amt_t'(vol_s);
        endcase
    end

    // All volumes divide by four exactly
    assign half = base >> 1;
    assign quarter = base >> 2;
    assign three_q = half + quarter;

    always_comb
    begin
        for (int i = 0; i < num_ing; i++)
        begin
            demand[i] = '0;
        end
        case (cur_type)
            black_tea:
                demand[0] = base;
            milk_tea:
            begin
                demand[0] = three_q;
                demand[2] = quarter;
            end
            extra_milk_tea:
            begin
                demand[0] = half;
                demand[2] = half;
            end
            green_tea:
                demand[1] = base;
            green_milk_tea:
            begin
                demand[1] = half;
                demand[2] = half;
            end
            pineapple_juice:
                demand[3] = base;
            super_pineapple_tea:
            begin
                demand[0] = half;
                demand[3] = half;
            end
            super_pineapple_milk_tea:
            begin
                demand[0] = half;
                demand[2] = quarter;
                demand[3] = quarter;
            end
            default:
                demand[0] = base;
        endcase
    end

endmodule

// File: design/stock_judge.sv
`timescale 1ns/1ps

module stock_judge import bev_pkg::*;
(
    input  logic               clk,
    input  logic               rec_load,
    input  logic               judge_en,
    input  logic               wb_en,
    input  record_t            c_data_r,
    input  action_t            cur_action,
    input  month_t             cur_month,
    input  day_t               cur_day,
    input  ing_amt_t           made [num_ing],
    input  logic [num_ing-1:0] run_out,
    input  ing_amt_t           supplied [num_ing],
    input  logic [num_ing-1:0] overflow,
    output ing_amt_t           lane_stock [num_ing],
    output record_t            c_data_w,
    output err_msg_t           err_msg_out,
    output logic               complete_out
);

    record_t rec;
    record_t rec_next;
    month_t  rec_month;
    day_t    rec_day;
    logic    expired;

    assign rec_month = rec[rec_month_lsb +: $bits(month_t)];
    assign rec_day = rec[rec_day_lsb +: $bits(day_t)];
    // Stored date earlier than today
    assign expired = {rec_month, rec_day} < {cur_month, cur_day};

    always_comb
    begin
        for (int i = 0; i < num_ing; i++)
        begin
            lane_stock[i] = rec[ing_lsb[i] +: $bits(ing_amt_t)];
        end
    end

    // Expiry outranks run-out
    always_comb
    begin
        err_msg_out = no_err;
        case (cur_action)
            make_drink:
            begin
                if (expired)
                    err_msg_out = no_exp;
                else if (|run_out)
                    err_msg_out = no_ing;
            end
            supply:
            begin
                if (|overflow)
                    err_msg_out = ing_of;
            end
            check_date:
            begin
                if (expired)
                    err_msg_out = no_exp;
            end
            default:
                err_msg_out = no_err;
        endcase
    end

    assign complete_out = (err_msg_out == no_err);

    always_comb
    begin
        rec_next = rec;
        if (cur_action == supply)
        begin
            for (int i = 0; i < num_ing; i++)
            begin
                rec_next[ing_lsb[i] +: $bits(ing_amt_t)] = supplied[i];
            end
            rec_next[rec_month_lsb +: $bits(month_t)] = cur_month;
            rec_next[rec_day_lsb +: $bits(day_t)] = cur_day;
        end
        else if (cur_action == make_drink && err_msg_out == no_err)
        begin
            for (int i = 0; i < num_ing; i++)
            begin
                rec_next[ing_lsb[i] +: $bits(ing_amt_t)] = made[i];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rec_load)
            rec <= c_data_r;
        else if (judge_en)
            rec <= rec_next;
    end

    assign c_data_w = wb_en ? rec : '0;

endmodule

// File: design/bev_ctrl.sv
`timescale 1ns/1ps

module bev_ctrl import bev_pkg::*;
(
    input  logic      clk,
    input  logic      inf,
    input  logic      sel_action_valid,
    input  action_t   action,
    input  logic      type_valid,
    input  bev_type_t bev_type,
    input  logic      size_valid,
    input  bev_size_t bev_size,
    input  logic      date_valid,
    input  month_t    month,
    input  day_t      day,
    input  logic      box_no_valid,
    input  box_no_t   box_no,
    input  logic      box_sup_valid,
    input  logic      c_out_valid,
    input  err_msg_t  err_msg_in,
    input  logic      complete_in,
    output action_t   cur_action,
    output bev_type_t cur_type,
    output bev_size_t cur_size,
    output month_t    cur_month,
    output day_t      cur_day,
    output logic [1:0] sup_cnt,
    output logic      sup_capture,
    output logic      rec_load,
    output logic      judge_en,
    output logic      c_in_valid,
    output box_no_t   c_addr,
    output logic      c_r_wb,
    output logic      wb_en,
    output logic      out_valid,
    output err_msg_t  err_msg,
    output logic      complete
);

    typedef enum logic [3:0]
    {
        idle, get_type, get_size, get_date, get_box, get_supplies,
        read_req, read_wait, judge, report, write_req, write_wait
    } state_t;

    state_t  state;
    state_t  state_next;
    box_no_t box_q;
    logic    need_write;

    // Failed make drink leaves the record untouched
    assign need_write = (cur_action == supply) ||
                        (cur_action == make_drink && err_msg == no_err);

    always_ff @(posedge clk or negedge inf)
    begin
        if (!inf)
            state <= idle;
        else
            state <= state_next;
    end

    always_comb
    begin
        state_next = state;
        case (state)
            idle:
            begin
                if (sel_action_valid)
                begin
                    if (action == make_drink)
                        state_next = get_type;
                    else if (action == supply || action == check_date)
                        state_next = get_date;
                end
            end
            get_type:
                state_next = type_valid ? get_size : get_type;
            get_size:
                state_next = size_valid ? get_date : get_size;
            get_date:
                state_next = date_valid ? get_box : get_date;
            get_box:
            begin
                if (box_no_valid)
                    state_next = (cur_action == supply) ? get_supplies : read_req;
            end
            get_supplies:
            begin
                if (box_sup_valid && sup_cnt == 2'd3)
                    state_next = read_req;
            end
            read_req:
                state_next = read_wait;
            read_wait:
                state_next = c_out_valid ? judge : read_wait;
            judge:
                state_next = report;
            report:
                state_next = need_write ? write_req : idle;
            write_req:
                state_next = write_wait;
            write_wait:
                state_next = c_out_valid ? idle : write_wait;
            default:
                state_next = idle;
        endcase
    end

    // Operands are taken only in the phase expecting them
    always_ff @(posedge clk)
    begin
        if (state == idle && sel_action_valid)
            cur_action <= action;
        if (state == get_type && type_valid)
            cur_type <= bev_type;
        if (state == get_size && size_valid)
            cur_size <= bev_size;
        if (state == get_date && date_valid)
        begin
            cur_month <= month;
            cur_day <= day;
        end
        if (state == get_box && box_no_valid)
            box_q <= box_no;
    end

    always_ff @(posedge clk or negedge inf)
    begin
        if (!inf)
            sup_cnt <= 2'd0;
        else if (state == idle)
            sup_cnt <= 2'd0;
        else if (sup_capture)
            sup_cnt <= sup_cnt + 2'd1;
    end

    // Verdict held for the single report cycle
    always_ff @(posedge clk or negedge inf)
    begin
        if (!inf)
        begin
            out_valid <= 1'b0;
            err_msg <= no_err;
            complete <= 1'b0;
        end
        else if (state == judge)
        begin
            out_valid <= 1'b1;
            err_msg <= err_msg_in;
            complete <= complete_in;
        end
        else
        begin
            out_valid <= 1'b0;
            err_msg <= no_err;
            complete <= 1'b0;
        end
    end

    assign sup_capture = (state == get_supplies) && box_sup_valid;
    assign rec_load = (state == read_wait) && c_out_valid;
    assign judge_en = (state == judge);
    assign wb_en = (state == write_req);

    // One-cycle bridge request
    assign c_in_valid = (state == read_req) || (state == write_req);
    assign c_r_wb = (state == read_req);
    assign c_addr = box_q;

endmodule

// File: design/bev_top.sv
`timescale 1ns/1ps

module bev_top import bev_pkg::*;
(
    input  logic      clk,
    input  logic      inf,
    input  logic      sel_action_valid,
    input  action_t   action,
    input  logic      type_valid,
    input  bev_type_t bev_type,
    input  logic      size_valid,
    input  bev_size_t bev_size,
    input  logic      date_valid,
    input  month_t    month,
    input  day_t      day,
    input  logic      box_no_valid,
    input  box_no_t   box_no,
    input  logic      box_sup_valid,
    input  ing_amt_t  sup_amt,
    output logic      out_valid,
    output err_msg_t  err_msg,
    output logic      complete,
    output logic      c_in_valid,
    output box_no_t   c_addr,
    output logic      c_r_wb,
    output record_t   c_data_w,
    input  logic      c_out_valid,
    input  record_t   c_data_r
);

    action_t            cur_action;
    bev_type_t          cur_type;
    bev_size_t          cur_size;
    month_t             cur_month;
    day_t               cur_day;
    logic [1:0]         sup_cnt;
    logic               sup_capture;
    logic               rec_load;
    logic               judge_en;
    logic               wb_en;
    err_msg_t           verdict;
    logic               verdict_ok;
    ing_amt_t           demand [num_ing];
    ing_amt_t           lane_stock [num_ing];
    ing_amt_t           made [num_ing];
    ing_amt_t           supplied [num_ing];
    logic [num_ing-1:0] run_out;
    logic [num_ing-1:0] overflow;

    bev_ctrl u_ctrl (
        .clk              (clk),
        .inf              (inf),
        .sel_action_valid (sel_action_valid),
        .action           (action),
        .type_valid       (type_valid),
        .bev_type         (bev_type),
        .size_valid       (size_valid),
        .bev_size         (bev_size),
        .date_valid       (date_valid),
        .month            (month),
        .day              (day),
        .box_no_valid     (box_no_valid),
        .box_no           (box_no),
        .box_sup_valid    (box_sup_valid),
        .c_out_valid      (c_out_valid),
        .err_msg_in       (verdict),
        .complete_in      (verdict_ok),
        .cur_action       (cur_action),
        .cur_type         (cur_type),
        .cur_size         (cur_size),
        .cur_month        (cur_month),
        .cur_day          (cur_day),
        .sup_cnt          (sup_cnt),
        .sup_capture      (sup_capture),
        .rec_load         (rec_load),
        .judge_en         (judge_en),
        .c_in_valid       (c_in_valid),
        .c_addr           (c_addr),
        .c_r_wb           (c_r_wb),
        .wb_en            (wb_en),
        .out_valid        (out_valid),
        .err_msg          (err_msg),
        .complete         (complete)
    );

    recipe_decode u_recipe (
        .cur_type (cur_type),
        .cur_size (cur_size),
        .demand   (demand)
    );

    for (genvar i = 0; i < num_ing; i++)
    begin : g_lane
        ingredient_lane #(
            .lane_idx (i)
        ) u_lane (
            .clk         (clk),
            .sup_capture (sup_capture),
            .sup_cnt     (sup_cnt),
            .sup_amt     (sup_amt),
            .stock       (lane_stock[i]),
            .demand      (demand[i]),
            .made        (made[i]),
            .run_out     (run_out[i]),
            .supplied    (supplied[i]),
            .overflow    (overflow[i])
        );
    end

    stock_judge u_judge (
        .clk          (clk),
        .rec_load     (rec_load),
        .judge_en     (judge_en),
        .wb_en        (wb_en),
        .c_data_r     (c_data_r),
        .cur_action   (cur_action),
        .cur_month    (cur_month),
        .cur_day      (cur_day),
        .made         (made),
        .run_out      (run_out),
        .supplied     (supplied),
        .overflow     (overflow),
        .lane_stock   (lane_stock),
        .c_data_w     (c_data_w),
        .err_msg_out  (verdict),
        .complete_out (verdict_ok)
    );

endmodule

// File: test/dram_bridge_model.sv
`timescale 1ns/1ps

module dram_bridge_model import bev_pkg::*;
(
    input  logic    clk,
    input  logic    inf,
    input  logic    c_in_valid,
    input  box_no_t c_addr,
    input  logic    c_r_wb,
    input  record_t c_data_w,
    output logic    c_out_valid,
    output record_t c_data_r,
    input  record_t rd_record,
    input  box_no_t exp_addr,
    input  logic    exp_write,
    input  record_t exp_wdata,
    output int      rd_cnt,
    output int      wr_cnt,
    output int      ack_cnt,
    output int      err_cnt
);

    integer seed;

    initial
    begin
        int   delay;
        logic is_read;
        seed = 32'h850e06e6;
        c_out_valid = 1'b0;
        c_data_r = '0;
        rd_cnt = 0;
        wr_cnt = 0;
        ack_cnt = 0;
        err_cnt = 0;
        forever
        begin
            @(posedge clk);
            if (inf && c_in_valid)
            begin
                is_read = c_r_wb;
                if (is_read)
                    rd_cnt++;
                else
                    wr_cnt++;
                assert (c_addr == exp_addr)
                else
                begin
                    err_cnt++;
                    $display("MISMATCH at %0t ns: bridge address %02h, expected %02h",
                        $time, c_addr, exp_addr);
                end
                if (!is_read)
                begin
                    assert (exp_write)
                    else
                    begin
                        err_cnt++;
                        $display("Bridge got a write request although none was due");
                    end
                    if (exp_write)
                    begin
                        assert (c_data_w == exp_wdata)
                        else
                        begin
                            err_cnt++;
                            $display("MISMATCH at %0t ns: written record %016h, expected %016h",
                                $time, c_data_w, exp_wdata);
                        end
                    end
                end
                // Answer after 1 to 6 cycles
                delay = 1 + int'($unsigned($random(seed)) % 32'd6);
                repeat (delay) @(negedge clk);
                c_out_valid = 1'b1;
                c_data_r = is_read ? rd_record : '0;
                @(posedge clk);
                ack_cnt++;
                @(negedge clk);
                c_out_valid = 1'b0;
                c_data_r = '0;
            end
        end
    end

endmodule

// File: test/tb_bev.sv
`timescale 1ns/1ps

module tb_bev import bev_pkg::*;
();

    localparam int fields = 15;
    localparam int max_cmds = 64;
    localparam int timeout_cycles = 200;

    logic      clk;
    logic      inf;
    logic      sel_action_valid;
    action_t   action;
    logic      type_valid;
    bev_type_t bev_type;
    logic      size_valid;
    bev_size_t bev_size;
    logic      date_valid;
    month_t    month;
    day_t      day;
    logic      box_no_valid;
    box_no_t   box_no;
    logic      box_sup_valid;
    ing_amt_t  sup_amt;
    logic      out_valid;
    err_msg_t  err_msg;
    logic      complete;
    logic      c_in_valid;
    box_no_t   c_addr;
    logic      c_r_wb;
    record_t   c_data_w;
    logic      c_out_valid;
    record_t   c_data_r;

    logic [63:0] stim_mem [0:fields*max_cmds];
    record_t     rd_record;
    box_no_t     exp_addr;
    logic        exp_write;
    record_t     exp_wdata;
    int          rd_cnt;
    int          wr_cnt;
    int          ack_cnt;
    int          bridge_errs;
    int          errors;
    int          checks;
    int          num_cmds;
    logic        run_aborted;

    bev_top u_dut (
        .clk (clk), .inf (inf),
        .sel_action_valid (sel_action_valid), .action (action),
        .type_valid (type_valid), .bev_type (bev_type),
        .size_valid (size_valid), .bev_size (bev_size),
        .date_valid (date_valid), .month (month), .day (day),
        .box_no_valid (box_no_valid), .box_no (box_no),
        .box_sup_valid (box_sup_valid), .sup_amt (sup_amt),
        .out_valid (out_valid), .err_msg (err_msg), .complete (complete),
        .c_in_valid (c_in_valid), .c_addr (c_addr), .c_r_wb (c_r_wb),
        .c_data_w (c_data_w), .c_out_valid (c_out_valid), .c_data_r (c_data_r)
    );

    dram_bridge_model u_bridge (
        .clk (clk), .inf (inf),
        .c_in_valid (c_in_valid), .c_addr (c_addr), .c_r_wb (c_r_wb),
        .c_data_w (c_data_w), .c_out_valid (c_out_valid), .c_data_r (c_data_r),
        .rd_record (rd_record), .exp_addr (exp_addr),
        .exp_write (exp_write), .exp_wdata (exp_wdata),
        .rd_cnt (rd_cnt), .wr_cnt (wr_cnt), .ack_cnt (ack_cnt), .err_cnt (bridge_errs)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic report_error(input string msg);
        errors++;
        $display("MISMATCH at %0t ns: %s", $time, msg);
    endtask

    // Host outputs stay quiet outside the report cycle
    task automatic next_cycle();
        @(negedge clk);
        checks++;
        assert (out_valid == 1'b0 && err_msg == no_err && complete == 1'b0)
        else
            report_error($sformatf("outputs not idle, out_valid %0b err %0d complete %0b",
                out_valid, err_msg, complete));
    endtask

    task automatic send_command(input int base);
        action_t act;
        int i;
        act = action_t'(stim_mem[base][1:0]);
        next_cycle();
        sel_action_valid = 1'b1;
        action = act;
        next_cycle();
        sel_action_valid = 1'b0;
        if (act == make_drink)
        begin
            type_valid = 1'b1;
            bev_type = bev_type_t'(stim_mem[base + 1][2:0]);
            next_cycle();
            type_valid = 1'b0;
            size_valid = 1'b1;
            bev_size = bev_size_t'(stim_mem[base + 2][1:0]);
            next_cycle();
            size_valid = 1'b0;
        end
        date_valid = 1'b1;
        month = stim_mem[base + 3][7:0];
        day = stim_mem[base + 4][7:0];
        next_cycle();
        date_valid = 1'b0;
        box_no_valid = 1'b1;
        box_no = stim_mem[base + 5][7:0];
        next_cycle();
        box_no_valid = 1'b0;
        if (act == supply)
        begin
            for (i = 0; i < num_ing; i++)
            begin
                box_sup_valid = 1'b1;
                sup_amt = stim_mem[base + 6 + i][11:0];
                next_cycle();
                box_sup_valid = 1'b0;
            end
        end
    endtask

    task automatic wait_report(output logic seen);
        int n;
        seen = 1'b0;
        n = 0;
        while (!seen && n < timeout_cycles)
        begin
            @(negedge clk);
            seen = out_valid;
            n++;
        end
    endtask

    task automatic wait_acks(input int target, output logic done);
        int n;
        n = 0;
        while (ack_cnt < target && n < timeout_cycles)
        begin
            next_cycle();
            n++;
        end
        done = (ack_cnt >= target);
    endtask

    task automatic run_command(input int k);
        int   base;
        int   rd_before;
        int   wr_before;
        int   ack_before;
        logic seen;
        logic done;
        base = 1 + k * fields;
        rd_record = stim_mem[base + 10];
        exp_addr = stim_mem[base + 5][7:0];
        exp_write = stim_mem[base + 13][0];
        exp_wdata = stim_mem[base + 14];
        rd_before = rd_cnt;
        wr_before = wr_cnt;
        ack_before = ack_cnt;
        send_command(base);
        wait_report(seen);
        if (!seen)
        begin
            $display("Command %0d got no out_valid within %0d cycles", k, timeout_cycles);
            run_aborted = 1'b1;
        end
        else
        begin
            checks++;
            assert (err_msg == err_msg_t'(stim_mem[base + 11][1:0]))
            else
                report_error($sformatf("command %0d err_msg %0d, expected %0d",
                    k, err_msg, stim_mem[base + 11][1:0]));
            checks++;
            assert (complete == stim_mem[base + 12][0])
            else
                report_error($sformatf("command %0d complete %0b, expected %0b",
                    k, complete, stim_mem[base + 12][0]));
            wait_acks(ack_before + (exp_write ? 2 : 1), done);
            if (!done)
            begin
                $display("Command %0d never saw its bridge acknowledge", k);
                run_aborted = 1'b1;
            end
            else
            begin
                // A write would follow out_valid within a cycle
                repeat (4) next_cycle();
                checks++;
                assert (rd_cnt == rd_before + 1)
                else
                    report_error($sformatf("command %0d issued %0d reads",
                        k, rd_cnt - rd_before));
                checks++;
                assert (wr_cnt == wr_before + (exp_write ? 1 : 0))
                else
                    report_error($sformatf("command %0d issued %0d writes",
                        k, wr_cnt - wr_before));
            end
        end
    endtask

    initial
    begin
        int k;
        inf = 1'b0;
        sel_action_valid = 1'b0;
        action = make_drink;
        type_valid = 1'b0;
        bev_type = black_tea;
        size_valid = 1'b0;
        bev_size = size_s;
        date_valid = 1'b0;
        month = '0;
        day = '0;
        box_no_valid = 1'b0;
        box_no = '0;
        box_sup_valid = 1'b0;
        sup_amt = '0;
        rd_record = '0;
        exp_addr = '0;
        exp_write = 1'b0;
        exp_wdata = '0;
        errors = 0;
        checks = 0;
        run_aborted = 1'b0;
        $readmemh("test/bev_stim.txt", stim_mem);
        num_cmds = int'(stim_mem[0][31:0]);
        repeat (4) @(negedge clk);
        checks++;
        assert (out_valid == 1'b0 && complete == 1'b0 && c_in_valid == 1'b0 && err_msg == no_err)
        else
            report_error("outputs not cleared by reset");
        inf = 1'b1;
        if (num_cmds < 1 || num_cmds > max_cmds)
        begin
            $display("Stimulus file holds an invalid command count %0d", num_cmds);
            run_aborted = 1'b1;
        end
        k = 0;
        while (!run_aborted && k < num_cmds)
        begin
            run_command(k);
            k++;
        end
        $display("Commands %0d, checks %0d, testbench errors %0d, bridge errors %0d",
            k, checks, errors, bridge_errs);
        if (errors == 0 && bridge_errs == 0 && !run_aborted)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

// File: project.f
design/bev_pkg.sv
design/ingredient_lane.sv
design/recipe_decode.sv
design/stock_judge.sv
design/bev_ctrl.sv
design/bev_top.sv
test/dram_bridge_model.sv
test/tb_bev.sv

// File: Makefile
# Verilator build and run of the beverage controller testbench

TOP = tb_bev
OBJ = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check sim.log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -Mdir $(OBJ) -f project.f
	./$(OBJ)/V$(TOP) | tee sim.log
	@grep -q "ALL CHECKS PASSED" sim.log || (echo "Simulation failed, see sim.log"; exit 1)

clean:
	rm -rf $(OBJ) sim.log

// File: test/bev_stim.txt
// First word: number of commands (hex). Then one command per line, all fields hex:
// action type size month day box sup0 sup1 sup2 sup3 record err complete write wrecord
12
0 0 0 06 0F 03 0 0 0 0 8008000C8008001F 0 1 1 6208000C8008001F
0 1 1 06 0F 11 0 0 0 0 8008000C8008001F 0 1 1 5E48000C74C8001F
0 2 2 06 0F 22 0 0 0 0 8008000C8008001F 0 1 1 6208000C6208001F
0 3 1 06 0F 23 0 0 0 0 8008000C8008001F 0 1 1 8005300C8008001F
0 4 0 06 0F 24 0 0 0 0 8008000C8008001F 0 1 1 8007100C7108001F
0 5 2 06 0F 25 0 0 0 0 8008000C8008001F 0 1 1 8008000C8004401F
0 6 1 06 0F 26 0 0 0 0 8008000C8008001F 0 1 1 6988000C8006981F
0 7 2 06 0F 27 0 0 0 0 8008000C8008001F 0 1 1 6208000C7107101F
0 3 2 06 0F 40 0 0 0 0 8003C00C8008001F 0 1 1 8000000C8008001F
0 0 0 06 0F 41 0 0 0 0 800800058008000F 1 0 0 0
0 1 2 06 0F 42 0 0 0 0 8008000C0EF8001F 2 0 0 0
0 1 0 06 0F 43 0 0 0 0 800800050008000F 1 0 0 0
1 0 0 06 0F 50 10 20 30 40 1002000330040005 0 1 1 110220063304400F
1 0 0 06 0F 51 200 50 60 70 F001000820030010 3 0 1 FFF150062603700F
1 0 0 06 0F 52 0 FFF FFE 0 FFF0000100100001 0 1 1 FFFFFF06FFF0000F
2 0 0 06 0F 60 0 0 0 0 800800068008000E 1 0 0 0
2 0 0 06 0F 61 0 0 0 0 800800068008000F 0 1 0 0
2 0 0 06 0F 62 0 0 0 0 8008000780080001 0 1 0 0
